//--- vlog.f
common/rab_cfg_pkg.sv
common/rab_req_pkg.sv
slice/rab_slice.sv
slice/rab_slice_array.sv
verilog/rab_port_arbiter.sv
verilog/rab_decision_fsm.sv
verilog/rab_core.sv
tb/tb_rab_core.sv

//--- run_sim.sh
#!/bin/bash
# build and run the RAB core testbench with Verilator

verilator --binary --timing --assert --top-module tb_rab_core -f vlog.f -o sim_rab \
  > build.log 2>&1 \
  && ./obj_dir/sim_rab > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

//--- tb/tb_rab_core.sv
// RAB core testbench
`timescale 1ns/100ps
`default_nettype none

module tb_rab_core;

  localparam int N_DIRECTED = 10;
  localparam int N_RANDOM   = 200;
  // config writes and reset come on top of eight cycles per request
  localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 8 + 8 + 40;

  typedef struct packed {
    logic        accept;
    logic        miss;
    logic        imiss;
    logic        iprot;
    logic        imulti;
    logic        ipref;
    logic        coherent;
    logic [39:0] out_addr;
  } expect_t;

  logic                                Clk_CI;
  logic                                Rst_RBI;
  logic                                cfg_we;
  logic [rab_cfg_pkg::CFG_ADDR_W-1:0]  cfg_addr;
  logic [rab_cfg_pkg::CFG_DATA_W-1:0]  cfg_wdata;
  rab_req_pkg::rab_req_t               rd_req;
  rab_req_pkg::rab_req_t               wr_req;
  logic                                rd_valid, rd_sent, wr_valid, wr_sent;
  logic                                rd_accept, rd_drop, rd_miss;
  logic                                wr_accept, wr_drop, wr_miss;
  logic [rab_cfg_pkg::PADDR_W-1:0]     out_addr;
  logic                                coherent;
  logic                                int_miss, int_prot, int_multi, int_prefetch;
  rab_req_pkg::rab_fault_t             fault;

  // software view of the slice table
  logic [31:0] sl_start [4];
  logic [31:0] sl_end   [4];
  logic [39:0] sl_off   [4];
  logic [3:0]  sl_flags [4];

  rab_req_pkg::rab_req_t rd_q[$];
  rab_req_pkg::rab_req_t wr_q[$];
  logic        prio_rd;
  logic [31:0] lcg_state;
  int          errors;
  int          cycles;
  int          n_done;

  rab_core rab_core_inst (
    .Clk_CI (Clk_CI), .Rst_RBI (Rst_RBI),
    .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .rd_req_i (rd_req), .rd_valid_i (rd_valid), .rd_sent_i (rd_sent),
    .wr_req_i (wr_req), .wr_valid_i (wr_valid), .wr_sent_i (wr_sent),
    .rd_accept_o (rd_accept), .rd_drop_o (rd_drop), .rd_miss_o (rd_miss),
    .wr_accept_o (wr_accept), .wr_drop_o (wr_drop), .wr_miss_o (wr_miss),
    .out_addr_o (out_addr), .coherent_o (coherent),
    .int_miss_o (int_miss), .int_prot_o (int_prot), .int_multi_o (int_multi),
    .int_prefetch_o (int_prefetch), .fault_o (fault)
  );

  always #20 Clk_CI = ~Clk_CI;

  always @(posedge Clk_CI) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the DUT stopped answering after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // every accept or drop pulse is one answered request
  always @(posedge Clk_CI) begin
    if (rd_accept || rd_drop || wr_accept || wr_drop) begin
      n_done <= n_done + 1;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic rab_req_pkg::rab_req_t make_req(input logic [31:0] addr,
      input logic [7:0] id, input logic [7:0] len, input logic [2:0] size,
      input logic [5:0] user);
    rab_req_pkg::rab_req_t r;
    r.addr = addr;
    r.id   = id;
    r.len  = len;
    r.size = size;
    r.user = user;
    return r;
  endfunction

  // expected outcome from the table rules
  function automatic expect_t ref_outcome(input rab_req_pkg::rab_req_t r, input logic wr);
    expect_t     e;
    logic [31:0] first;
    logic [31:0] last;
    int          hits;
    logic        prot;
    e     = '0;
    hits  = 0;
    prot  = 1'b0;
    first = r.addr & ~((32'd1 << r.size) - 32'd1);
    last  = first + ((32'(r.len) + 32'd1) << r.size) - 32'd1;
    for (int i = 3; i >= 0; i--) begin
      if (sl_flags[i][0] && r.addr >= sl_start[i] && last <= sl_end[i]) begin
        hits++;
        if (wr ? !sl_flags[i][2] : !sl_flags[i][1]) prot = 1'b1;
        e.out_addr = 40'(r.addr - sl_start[i]) + sl_off[i];
        e.coherent = sl_flags[i][3];
      end
    end
    e.accept = (hits == 1) && !prot;
    e.imulti = hits > 1;
    e.iprot  = !e.imulti && hits == 1 && prot;
    e.ipref  = hits == 0 && (&r.user);
    e.imiss  = hits == 0 && !(&r.user);
    e.miss   = e.imiss;
    return e;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic cfg_write(input int slice, input int field, input logic [63:0] data);
    @(posedge Clk_CI);
    cfg_we    <= 1'b1;
    cfg_addr  <= 4'(slice * 4 + field);
    cfg_wdata <= data;
    case (field)
      0: sl_start[slice] = data[31:0];
      1: sl_end[slice]   = data[31:0];
      2: sl_off[slice]   = data[39:0];
      default: sl_flags[slice] = data[3:0];
    endcase
    @(posedge Clk_CI);
    cfg_we <= 1'b0;
  endtask

  task automatic setup_slice(input int s, input logic [31:0] lo, input logic [31:0] hi,
      input logic [39:0] off, input logic [3:0] flags);
    cfg_write(s, 0, 64'(lo));
    cfg_write(s, 1, 64'(hi));
    cfg_write(s, 2, 64'(off));
    cfg_write(s, 3, 64'(flags));
  endtask

  task automatic no_strobe_check();
    assert (!(rd_accept || rd_drop || wr_accept || wr_drop)) else begin
      $display("a strobe fired while no decision was due");
      errors++;
    end
  endtask

  // drain both request queues and hold sent back for hold cycles after each accept
  task automatic serve(input int hold);
    logic                  rd_act, wr_act, sel_rd;
    rab_req_pkg::rab_req_t cur;
    expect_t               e;
    @(posedge Clk_CI);
    rd_act = rd_q.size() > 0;
    wr_act = wr_q.size() > 0;
    if (rd_act) rd_req <= rd_q[0];
    if (wr_act) wr_req <= wr_q[0];
    rd_valid <= rd_act;
    wr_valid <= wr_act;
    while (rd_act || wr_act) begin
      sel_rd = !wr_act || (rd_act && prio_rd);
      cur = sel_rd ? rd_q.pop_front() : wr_q.pop_front();
      e = ref_outcome(cur, !sel_rd);
      // answer is due exactly two edges after sampling
      repeat (2) begin
        @(negedge Clk_CI);
        no_strobe_check();
      end
      @(negedge Clk_CI);
      check_val("rd_accept_o", 64'(rd_accept), 64'(e.accept && sel_rd));
      check_val("wr_accept_o", 64'(wr_accept), 64'(e.accept && !sel_rd));
      check_val("rd_drop_o", 64'(rd_drop), 64'(!e.accept && sel_rd));
      check_val("wr_drop_o", 64'(wr_drop), 64'(!e.accept && !sel_rd));
      check_val("rd_miss_o", 64'(rd_miss), 64'(e.miss && sel_rd));
      check_val("wr_miss_o", 64'(wr_miss), 64'(e.miss && !sel_rd));
      check_val("int_miss_o", 64'(int_miss), 64'(e.imiss));
      check_val("int_prot_o", 64'(int_prot), 64'(e.iprot));
      check_val("int_multi_o", 64'(int_multi), 64'(e.imulti));
      check_val("int_prefetch_o", 64'(int_prefetch), 64'(e.ipref));
      if (e.accept) begin
        check_val("out_addr_o", 64'(out_addr), 64'(e.out_addr));
        check_val("coherent_o", 64'(coherent), 64'(e.coherent));
      end else begin
        check_val("fault_o.addr", 64'(fault.addr), 64'(cur.addr));
        check_val("fault_o.id", 64'(fault.id), 64'(cur.id));
        check_val("fault_o.len", 64'(fault.len), 64'(cur.len));
        check_val("fault_o.user", 64'(fault.user), 64'(cur.user));
      end
      prio_rd = !sel_rd;
      @(posedge Clk_CI);
      if (sel_rd) begin
        rd_act = rd_q.size() > 0;
        if (rd_act) rd_req <= rd_q[0];
        rd_valid <= rd_act;
      end else begin
        wr_act = wr_q.size() > 0;
        if (wr_act) wr_req <= wr_q[0];
        wr_valid <= wr_act;
      end
      if (e.accept) begin
        repeat (hold) begin
          @(negedge Clk_CI);
          no_strobe_check();
          @(posedge Clk_CI);
        end
        if (sel_rd) rd_sent <= 1'b1;
        else wr_sent <= 1'b1;
        @(posedge Clk_CI);
        rd_sent <= 1'b0;
        wr_sent <= 1'b0;
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] base;
    rab_req_pkg::rab_req_t rq;
    Clk_CI = 1'b0;
    Rst_RBI = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    rd_req = '0;
    wr_req = '0;
    rd_valid = 1'b0;
    wr_valid = 1'b0;
    rd_sent = 1'b0;
    wr_sent = 1'b0;
    prio_rd = 1'b1;
    lcg_state = 32'h55fe9a3b;
    errors = 0;
    cycles = 0;
    n_done = 0;
    for (int i = 0; i < 4; i++) begin
      sl_start[i] = '0;
      sl_end[i]   = '0;
      sl_off[i]   = '0;
      sl_flags[i] = '0;
    end
    repeat (8) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;

    // slice 0 is read-only and slice 1 read-write coherent
    setup_slice(0, 32'h1000_0000, 32'h1000_ffff, 40'h80_0000_0000, 4'b0011);
    setup_slice(1, 32'h2000_0000, 32'h2003_ffff, 40'h12_3400_0000, 4'b1111);

    rd_q.push_back(make_req(32'h1000_0100, 8'h01, 8'd3, 3'd2, 6'h00));
    serve(0);
    rd_q.push_back(make_req(32'h2001_0040, 8'h02, 8'd7, 3'd3, 6'h05));
    serve(0);
    rd_q.push_back(make_req(32'h1000_fff0, 8'h03, 8'd3, 3'd3, 6'h01));
    serve(0);
    wr_q.push_back(make_req(32'h5000_0000, 8'h04, 8'd0, 3'd0, 6'h02));
    serve(0);
    wr_q.push_back(make_req(32'h1000_0200, 8'h05, 8'd1, 3'd2, 6'h03));
    serve(0);
    rd_q.push_back(make_req(32'h6000_0000, 8'h06, 8'd0, 3'd1, 6'h3f));
    serve(0);

    // overlap for the multi-hit case only
    setup_slice(2, 32'h2001_0000, 32'h2001_ffff, 40'h00_4000_0000, 4'b0111);
    wr_q.push_back(make_req(32'h2001_0100, 8'h07, 8'd1, 3'd2, 6'h04));
    serve(0);
    cfg_write(2, 3, 64'h0);

    // both channels held valid while sent is withheld
    rd_q.push_back(make_req(32'h2000_0000, 8'h08, 8'd0, 3'd2, 6'h00));
    rd_q.push_back(make_req(32'h1000_0400, 8'h0a, 8'd2, 3'd1, 6'h00));
    wr_q.push_back(make_req(32'h2002_0000, 8'h09, 8'd4, 3'd2, 6'h00));
    serve(3);

    for (int i = 0; i < N_RANDOM; i++) begin
      r = lcg_next();
      case (r[1:0])
        2'd0: base = 32'h1000_0000;
        2'd1: base = 32'h2000_0000;
        2'd2: base = 32'h2003_f000;
        default: base = 32'h7000_0000;
      endcase
      rq = make_req(base + {15'd0, r[18:2]}, r[26:19], 8'(lcg_next() >> 24),
                    3'(r[29:27] % 4), r[31] ? 6'h3f : 6'(r[11:6]));
      if (r[30]) wr_q.push_back(rq);
      else rd_q.push_back(rq);
      if (r[5:4] != 2'd0 || i == N_RANDOM - 1) serve(0);
    end

    @(posedge Clk_CI);
    check_val("requests answered", 64'(n_done), 64'(N_DIRECTED + N_RANDOM));
    $display("%0d requests, %0d errors", n_done, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/rab_core.sv
// RAB core top level
`timescale 1ns/100ps
`default_nettype none

module rab_core (
  input  logic                                Clk_CI,
  input  logic                                Rst_RBI,
  input  logic                                cfg_we_i,
  input  logic [rab_cfg_pkg::CFG_ADDR_W-1:0]  cfg_addr_i,
  input  logic [rab_cfg_pkg::CFG_DATA_W-1:0]  cfg_wdata_i,
  input  rab_req_pkg::rab_req_t               rd_req_i,
  input  logic                                rd_valid_i,
  input  logic                                rd_sent_i,
  input  rab_req_pkg::rab_req_t               wr_req_i,
  input  logic                                wr_valid_i,
  input  logic                                wr_sent_i,
  output logic                                rd_accept_o,
  output logic                                rd_drop_o,
  output logic                                rd_miss_o,
  output logic                                wr_accept_o,
  output logic                                wr_drop_o,
  output logic                                wr_miss_o,
  output logic [rab_cfg_pkg::PADDR_W-1:0]     out_addr_o,
  output logic                                coherent_o,
  output logic                                int_miss_o,
  output logic                                int_prot_o,
  output logic                                int_multi_o,
  output logic                                int_prefetch_o,
  output rab_req_pkg::rab_fault_t             fault_o
);

  rab_req_pkg::rab_lookup_t lookup;
  rab_req_pkg::rab_result_t result;
  logic                     select_rd;
  logic                     rd_done;
  logic                     wr_done;

  // each served request moves the arbiter priority
  assign rd_done = rd_accept_o || rd_drop_o;
  assign wr_done = wr_accept_o || wr_drop_o;

  rab_port_arbiter port_arbiter_inst (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .rd_req_i    (rd_req_i),
    .wr_req_i    (wr_req_i),
    .rd_valid_i  (rd_valid_i),
    .wr_valid_i  (wr_valid_i),
    .rd_done_i   (rd_done),
    .wr_done_i   (wr_done),
    .lookup_o    (lookup),
    .select_rd_o (select_rd)
  );

  rab_slice_array slice_array_inst (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .lookup_i    (lookup),
    .result_o    (result)
  );

  rab_decision_fsm decision_fsm_inst (
    .Clk_CI         (Clk_CI),
    .Rst_RBI        (Rst_RBI),
    .lookup_i       (lookup),
    .select_rd_i    (select_rd),
    .rd_valid_i     (rd_valid_i),
    .wr_valid_i     (wr_valid_i),
    .rd_sent_i      (rd_sent_i),
    .wr_sent_i      (wr_sent_i),
    .result_i       (result),
    .rd_accept_o    (rd_accept_o),
    .rd_drop_o      (rd_drop_o),
    .rd_miss_o      (rd_miss_o),
    .wr_accept_o    (wr_accept_o),
    .wr_drop_o      (wr_drop_o),
    .wr_miss_o      (wr_miss_o),
    .out_addr_o     (out_addr_o),
    .coherent_o     (coherent_o),
    .int_miss_o     (int_miss_o),
    .int_prot_o     (int_prot_o),
    .int_multi_o    (int_multi_o),
    .int_prefetch_o (int_prefetch_o),
    .fault_o        (fault_o)
  );

endmodule

`default_nettype wire

//--- verilog/rab_decision_fsm.sv
// RAB accept/drop decision
`timescale 1ns/100ps
`default_nettype none

module rab_decision_fsm (
  input  logic                             Clk_CI,
  input  logic                             Rst_RBI,
  input  rab_req_pkg::rab_lookup_t         lookup_i,
  input  logic                             select_rd_i,
  input  logic                             rd_valid_i,
  input  logic                             wr_valid_i,
  input  logic                             rd_sent_i,
  input  logic                             wr_sent_i,
  input  rab_req_pkg::rab_result_t         result_i,
  output logic                             rd_accept_o,
  output logic                             rd_drop_o,
  output logic                             rd_miss_o,
  output logic                             wr_accept_o,
  output logic                             wr_drop_o,
  output logic                             wr_miss_o,
  output logic [rab_cfg_pkg::PADDR_W-1:0]  out_addr_o,
  output logic                             coherent_o,
  output logic                             int_miss_o,
  output logic                             int_prot_o,
  output logic                             int_multi_o,
  output logic                             int_prefetch_o,
  output rab_req_pkg::rab_fault_t          fault_o
);

  rab_req_pkg::decision_state_e state_q;
  rab_req_pkg::decision_state_e state_d;
  rab_req_pkg::rab_result_t     res_q;
  logic                         decide_q;
  logic                         sel_rd_q;
  logic                         start;
  logic                         accept_ok;
  logic                         sent;
  logic                         accept_cycle;
  logic                         drop_cycle;
  logic                         prefetch;
  logic                         plain_miss;

  assign start     = (state_q == rab_req_pkg::ST_IDLE) && (rd_valid_i || wr_valid_i);
  assign accept_ok = result_i.hit && !result_i.multi && !result_i.prot;
  assign sent      = sel_rd_q ? rd_sent_i : wr_sent_i;

  // decide_q marks the cycle after sampling, when the strobes get set
  assign accept_cycle = decide_q && (state_q == rab_req_pkg::ST_ACCEPT_WAIT);
  assign drop_cycle   = decide_q && (state_q == rab_req_pkg::ST_DROP);
  assign prefetch     = &fault_o.user;
  assign plain_miss   = drop_cycle && !res_q.multi && !res_q.prot && !prefetch;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rab_req_pkg::ST_IDLE: begin
        if (start) begin
          state_d = accept_ok ? rab_req_pkg::ST_ACCEPT_WAIT : rab_req_pkg::ST_DROP;
        end
      end
      rab_req_pkg::ST_ACCEPT_WAIT: begin
        // burst stays granted until the source has forwarded it
        if (!decide_q && sent) begin
          state_d = rab_req_pkg::ST_IDLE;
        end
      end
      rab_req_pkg::ST_DROP: begin
        if (!decide_q) begin
          state_d = rab_req_pkg::ST_IDLE;
        end
      end
      default: state_d = rab_req_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      state_q        <= rab_req_pkg::ST_IDLE;
      decide_q       <= 1'b0;
      sel_rd_q       <= 1'b1;
      rd_accept_o    <= 1'b0;
      wr_accept_o    <= 1'b0;
      rd_drop_o      <= 1'b0;
      wr_drop_o      <= 1'b0;
      rd_miss_o      <= 1'b0;
      wr_miss_o      <= 1'b0;
      int_multi_o    <= 1'b0;
      int_prot_o     <= 1'b0;
      int_prefetch_o <= 1'b0;
      int_miss_o     <= 1'b0;
    end else begin
      state_q  <= state_d;
      decide_q <= start;
      if (start) begin
        sel_rd_q <= select_rd_i;
      end
      rd_accept_o <= accept_cycle && sel_rd_q;
      wr_accept_o <= accept_cycle && !sel_rd_q;
      rd_drop_o   <= drop_cycle && sel_rd_q;
      wr_drop_o   <= drop_cycle && !sel_rd_q;
      rd_miss_o   <= plain_miss && sel_rd_q;
      wr_miss_o   <= plain_miss && !sel_rd_q;
      // one interrupt per drop, multi-hit first
      int_multi_o    <= drop_cycle && res_q.multi;
      int_prot_o     <= drop_cycle && !res_q.multi && res_q.prot;
      int_prefetch_o <= drop_cycle && !res_q.multi && !res_q.prot && prefetch;
      int_miss_o     <= plain_miss;
    end
  end

  // translation and request details captured with the decision
  always_ff @(posedge Clk_CI) begin
    if (start) begin
      res_q        <= result_i;
      fault_o.addr <= lookup_i.addr_min;
      fault_o.id   <= lookup_i.id;
      fault_o.len  <= lookup_i.len;
      fault_o.user <= lookup_i.user;
    end
  end

  assign out_addr_o = res_q.out_addr;
  assign coherent_o = res_q.coherent;

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !((rd_accept_o || wr_accept_o) && (rd_drop_o || wr_drop_o)));

  // every sampled request is answered two edges later
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    start |-> ##2 (rd_accept_o || wr_accept_o || rd_drop_o || wr_drop_o));

endmodule

`default_nettype wire

//--- verilog/rab_port_arbiter.sv
// RAB read/write arbiter
`timescale 1ns/100ps
`default_nettype none

module rab_port_arbiter (
  input  logic                     Clk_CI,
  input  logic                     Rst_RBI,
  input  rab_req_pkg::rab_req_t    rd_req_i,
  input  rab_req_pkg::rab_req_t    wr_req_i,
  input  logic                     rd_valid_i,
  input  logic                     wr_valid_i,
  input  logic                     rd_done_i,
  input  logic                     wr_done_i,
  output rab_req_pkg::rab_lookup_t lookup_o,
  output logic                     select_rd_o
);

  typedef logic [rab_cfg_pkg::VADDR_W-1:0] vaddr_t;

  logic   prio_rd_q;
  vaddr_t rd_end;
  vaddr_t wr_end;

  // last byte of the burst, start aligned down to the beat size
  function automatic vaddr_t burst_end(input rab_req_pkg::rab_req_t req);
    vaddr_t align_mask;
    vaddr_t n_bytes;
    align_mask = ~((vaddr_t'(1) << req.size) - vaddr_t'(1));
    n_bytes    = (vaddr_t'(req.len) + vaddr_t'(1)) << req.size;
    return (req.addr & align_mask) + n_bytes - vaddr_t'(1);
  endfunction

  assign rd_end = burst_end(rd_req_i);
  assign wr_end = burst_end(wr_req_i);

  // read wins when write is idle or when it holds priority
  assign select_rd_o = !wr_valid_i || (rd_valid_i && prio_rd_q);

  assign lookup_o.addr_min = select_rd_o ? rd_req_i.addr : wr_req_i.addr;
  assign lookup_o.addr_max = select_rd_o ? rd_end : wr_end;
  assign lookup_o.is_write = !select_rd_o;
  assign lookup_o.id       = select_rd_o ? rd_req_i.id : wr_req_i.id;
  assign lookup_o.len      = select_rd_o ? rd_req_i.len : wr_req_i.len;
  assign lookup_o.user     = select_rd_o ? rd_req_i.user : wr_req_i.user;

  // hand priority to the other channel after each service
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      prio_rd_q <= 1'b1;
    end else if (rd_done_i) begin
      prio_rd_q <= 1'b0;
    end else if (wr_done_i) begin
      prio_rd_q <= 1'b1;
    end
  end

  // the table never looks up an idle channel while the other one waits
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (rd_valid_i || wr_valid_i) |-> (select_rd_o ? rd_valid_i : wr_valid_i));

endmodule

`default_nettype wire

//--- slice/rab_slice_array.sv
// RAB L1 slice table
`timescale 1ns/100ps
`default_nettype none

module rab_slice_array (
  input  logic                                Clk_CI,
  input  logic                                Rst_RBI,
  input  logic                                cfg_we_i,
  input  logic [rab_cfg_pkg::CFG_ADDR_W-1:0]  cfg_addr_i,
  input  logic [rab_cfg_pkg::CFG_DATA_W-1:0]  cfg_wdata_i,
  input  rab_req_pkg::rab_lookup_t            lookup_i,
  output rab_req_pkg::rab_result_t            result_o
);

  logic [rab_cfg_pkg::N_SLICES-1:0]   slice_we;
  logic [rab_cfg_pkg::N_SLICES-1:0]   slice_hit;
  logic [rab_cfg_pkg::N_SLICES-1:0]   slice_prot;
  logic [rab_cfg_pkg::N_SLICES-1:0]   slice_coh;
  logic [rab_cfg_pkg::PADDR_W-1:0]    slice_addr [rab_cfg_pkg::N_SLICES];
  rab_cfg_pkg::slice_field_e          cfg_field;
  logic [rab_cfg_pkg::CFG_ADDR_W-1:0] cfg_slice;

  // word index is slice * N_FIELDS + field
  assign cfg_field = rab_cfg_pkg::slice_field_e'(
                       cfg_addr_i[$bits(rab_cfg_pkg::slice_field_e)-1:0]);
  assign cfg_slice = cfg_addr_i >> $bits(rab_cfg_pkg::slice_field_e);

  for (genvar i = 0; i < rab_cfg_pkg::N_SLICES; i++) begin : gen_slices
    assign slice_we[i] = cfg_we_i && (cfg_slice == rab_cfg_pkg::CFG_ADDR_W'(i));

    rab_slice slice_inst (
      .Clk_CI     (Clk_CI),
      .Rst_RBI    (Rst_RBI),
      .we_i       (slice_we[i]),
      .field_i    (cfg_field),
      .wdata_i    (cfg_wdata_i),
      .lookup_i   (lookup_i),
      .hit_o      (slice_hit[i]),
      .prot_o     (slice_prot[i]),
      .coherent_o (slice_coh[i]),
      .out_addr_o (slice_addr[i])
    );
  end

  always_comb begin
    result_o.hit = |slice_hit;
    // more than one bit set
    result_o.multi    = |(slice_hit & (slice_hit - rab_cfg_pkg::N_SLICES'(1)));
    result_o.prot     = |slice_prot;
    result_o.coherent = 1'b0;
    result_o.out_addr = '0;
    // lowest hitting slice wins the mux
    for (int i = rab_cfg_pkg::N_SLICES - 1; i >= 0; i--) begin
      if (slice_hit[i]) begin
        result_o.coherent = slice_coh[i];
        result_o.out_addr = slice_addr[i];
      end
    end
  end

  // configuration writes stay inside the table
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    cfg_we_i |-> (int'(cfg_addr_i) < rab_cfg_pkg::N_SLICES * rab_cfg_pkg::N_FIELDS));

endmodule

`default_nettype wire

//--- slice/rab_slice.sv
// RAB L1 slice
`timescale 1ns/100ps
`default_nettype none

module rab_slice (
  input  logic                                Clk_CI,
  input  logic                                Rst_RBI,
  input  logic                                we_i,
  input  rab_cfg_pkg::slice_field_e           field_i,
  input  logic [rab_cfg_pkg::CFG_DATA_W-1:0]  wdata_i,
  input  rab_req_pkg::rab_lookup_t            lookup_i,
  output logic                                hit_o,
  output logic                                prot_o,
  output logic                                coherent_o,
  output logic [rab_cfg_pkg::PADDR_W-1:0]     out_addr_o
);

  logic [rab_cfg_pkg::VADDR_W-1:0] va_start_q;
  logic [rab_cfg_pkg::VADDR_W-1:0] va_end_q;
  logic [rab_cfg_pkg::PADDR_W-1:0] offset_q;
  rab_cfg_pkg::slice_flags_t       flags_q;
  logic [rab_cfg_pkg::VADDR_W-1:0] rel_addr;

  // flags reset to zero so the slice starts disabled
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      flags_q <= '0;
    end else if (we_i && field_i == rab_cfg_pkg::FIELD_FLAGS) begin
      flags_q <= rab_cfg_pkg::slice_flags_t'(wdata_i[$bits(rab_cfg_pkg::slice_flags_t)-1:0]);
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (we_i && field_i == rab_cfg_pkg::FIELD_VA_START) begin
      va_start_q <= wdata_i[rab_cfg_pkg::VADDR_W-1:0];
    end
    if (we_i && field_i == rab_cfg_pkg::FIELD_VA_END) begin
      va_end_q <= wdata_i[rab_cfg_pkg::VADDR_W-1:0];
    end
    if (we_i && field_i == rab_cfg_pkg::FIELD_OFFSET) begin
      offset_q <= wdata_i[rab_cfg_pkg::PADDR_W-1:0];
    end
  end

  // whole burst must sit inside the inclusive range
  assign hit_o = flags_q.enable && (lookup_i.addr_min >= va_start_q)
                 && (lookup_i.addr_max <= va_end_q);
  assign prot_o = hit_o && (lookup_i.is_write ? !flags_q.write_allow : !flags_q.read_allow);
  assign coherent_o = flags_q.coherent;

  assign rel_addr   = lookup_i.addr_min - va_start_q;
  assign out_addr_o = rab_cfg_pkg::PADDR_W'(rel_addr) + offset_q;

endmodule

`default_nettype wire

//--- common/rab_req_pkg.sv
// RAB request and result types
`default_nettype none

package rab_req_pkg;

  // one channel's burst request
  typedef struct packed {
    logic [rab_cfg_pkg::VADDR_W-1:0] addr;
    logic [rab_cfg_pkg::ID_W-1:0]    id;
    logic [rab_cfg_pkg::LEN_W-1:0]   len;
    logic [rab_cfg_pkg::SIZE_W-1:0]  size;
    logic [rab_cfg_pkg::USER_W-1:0]  user;
  } rab_req_t;

  // selected burst as seen by the slice table
  typedef struct packed {
    logic [rab_cfg_pkg::VADDR_W-1:0] addr_min;
    logic [rab_cfg_pkg::VADDR_W-1:0] addr_max;
    logic                            is_write;
    logic [rab_cfg_pkg::ID_W-1:0]    id;
    logic [rab_cfg_pkg::LEN_W-1:0]   len;
    logic [rab_cfg_pkg::USER_W-1:0]  user;
  } rab_lookup_t;

  typedef struct packed {
    logic                            hit;
    logic                            prot;
    logic                            multi;
    logic                            coherent;
    logic [rab_cfg_pkg::PADDR_W-1:0] out_addr;
  } rab_result_t;

  // details reported with a fault interrupt
  typedef struct packed {
    logic [rab_cfg_pkg::VADDR_W-1:0] addr;
    logic [rab_cfg_pkg::ID_W-1:0]    id;
    logic [rab_cfg_pkg::LEN_W-1:0]   len;
    logic [rab_cfg_pkg::USER_W-1:0]  user;
  } rab_fault_t;

  typedef enum logic [1:0] {
    ST_IDLE        = 2'd0,
    ST_ACCEPT_WAIT = 2'd1,
    ST_DROP        = 2'd2
  } decision_state_e;

endpackage

`default_nettype wire

//--- common/rab_cfg_pkg.sv
// RAB table configuration
`default_nettype none

package rab_cfg_pkg;

  // address and AXI field widths
  localparam int VADDR_W = 32;
  localparam int PADDR_W = 40;
  localparam int ID_W    = 8;
  localparam int USER_W  = 6;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;

  // L1 table layout, four words per slice
  localparam int N_SLICES   = 4;
  localparam int N_FIELDS   = 4;
  localparam int CFG_ADDR_W = 4;
  localparam int CFG_DATA_W = 64;

  // word index within a slice
  typedef enum logic [1:0] {
    FIELD_VA_START = 2'd0,
    FIELD_VA_END   = 2'd1,
    FIELD_OFFSET   = 2'd2,
    FIELD_FLAGS    = 2'd3
  } slice_field_e;

  // low bits of the flags word, enable in bit 0
  typedef struct packed {
    logic coherent;
    logic write_allow;
    logic read_allow;
    logic enable;
  } slice_flags_t;

endpackage

`default_nettype wire
